/* filelist.f */
+incdir+src
src/lcd_pkg.sv
src/lcd_axi_slave.sv
src/lcd_char_ram.sv
src/lcd_refresh_fsm.sv
src/lcd_op_timer.sv
src/lcd_serial_tx.sv
src/lcd16032_axi.sv
verification/lcd_axi_checker.sv
verification/tb_lcd16032_axi.sv

/* Bender.yml */
package:
  name: lcd16032_axi

sources:
  - include_dirs:
      - src
    files:
      - src/lcd_pkg.sv
      - src/lcd_axi_slave.sv
      - src/lcd_char_ram.sv
      - src/lcd_refresh_fsm.sv
      - src/lcd_op_timer.sv
      - src/lcd_serial_tx.sv
      - src/lcd16032_axi.sv
  - target: test
    include_dirs:
      - src
    files:
      - verification/lcd_axi_checker.sv
      - verification/tb_lcd16032_axi.sv

/* verification/tb_lcd16032_axi.sv */
`timescale 1ns/10ps
`default_nettype none

`include "lcd_defines.svh"

module tb_lcd16032_axi
    import lcd_pkg::*;
();

    localparam int MAX_CYCLES = 80000;  // 4 phases x 3 passes of ~4.7k, plus setup
    localparam int N_PHASES   = 4;
    localparam int N_WRITES   = 40;

    logic                     S_AXI_ACLK, S_AXI_ARESETN;
    logic                     S_AXI_AWREADY, S_AXI_AWVALID, S_AXI_WREADY, S_AXI_WVALID;
    logic [`AXI_ADDR_W-1:0]   S_AXI_AWADDR, S_AXI_ARADDR;
    logic [2:0]               S_AXI_AWPROT, S_AXI_ARPROT;
    logic [`AXI_DATA_W-1:0]   S_AXI_WDATA, S_AXI_RDATA;
    logic [`AXI_DATA_W/8-1:0] S_AXI_WSTRB;
    logic [1:0]               S_AXI_BRESP, S_AXI_RRESP;
    logic                     S_AXI_BVALID, S_AXI_BREADY, S_AXI_ARREADY, S_AXI_ARVALID;
    logic                     S_AXI_RVALID, S_AXI_RREADY;
    logic                     lcd_cs, lcd_sck, lcd_mosi;

    logic [`AXI_DATA_W-1:0]   model [`LCD_NUM_WORDS];  // expected store contents
    logic [31:0]              rng = 32'd365;
    int                       cycle_cnt = 0;
    int                       last_b = -1;              // cycle of latest B handshake
    logic                     sck_q = 1'b0, cs_q = 1'b0;
    logic [23:0]              shift_in;
    int                       bit_n, frame_start;
    logic [23:0]              rx_raw [$];               // decoded frames
    int                       rx_start [$];             // cycle each frame began

    lcd16032_axi dut0 (.*);

    initial begin
        S_AXI_ACLK = 1'b0;
        forever #10 S_AXI_ACLK = ~S_AXI_ACLK;
    end

    function automatic logic [31:0] next_rand();
        rng ^= rng << 13;
        rng ^= rng >> 17;
        rng ^= rng << 5;
        return rng;
    endfunction

    function automatic lcd_frame_t mk_frame(lcd_op_e op, logic [7:0] payload);
        lcd_frame_t f;
        f.op      = op;
        f.payload = payload;
        return f;
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic check_frame(input string name, input lcd_frame_t exp, input lcd_frame_t got);
        if (got !== exp)
            abort_run($sformatf("** Error: %s exp=0x%h got=0x%h", name, exp, got));
    endtask

    task automatic check_word(input string name, input logic [`AXI_DATA_W-1:0] exp,
                              input logic [`AXI_DATA_W-1:0] got);
        if (got !== exp)
            abort_run($sformatf("** Error: %s exp=0x%h got=0x%h", name, exp, got));
    endtask

    task automatic check_resp(input string name, input logic [1:0] got);
        if (got !== 2'b00)
            abort_run($sformatf("** Error: %s exp=0x0 got=0x%h", name, got));
    endtask

    ////////////////////////////////////////////////////////////
    // cycle limit, bound assertions, serial decoder
    ////////////////////////////////////////////////////////////
    always @(posedge S_AXI_ACLK) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES)
            abort_run("timeout: run went past its cycle limit");
        if (dut0.chk0.fail_cnt != 0)
            abort_run("a bound protocol assertion failed");
    end

    always @(posedge S_AXI_ACLK) begin
        if (lcd_cs && !cs_q) begin              // new frame
            bit_n       = 0;
            frame_start = cycle_cnt;
        end
        if (lcd_cs && lcd_sck && !sck_q) begin  // slave-side sample point
            shift_in = {shift_in[22:0], lcd_mosi};
            bit_n++;
            if (bit_n == 24) begin
                rx_raw.push_back(shift_in);
                rx_start.push_back(frame_start);
            end
        end
        sck_q = lcd_sck;
        cs_q  = lcd_cs;
    end

    task automatic next_frame(output lcd_frame_t f, output int start);
        logic [23:0] raw;
        while (rx_raw.size() == 0)
            @(posedge S_AXI_ACLK);
        raw   = rx_raw.pop_front();
        start = rx_start.pop_front();
        if (raw[11:8] !== 4'h0 || raw[3:0] !== 4'h0)   // nibbles go out shifted up
            abort_run($sformatf("** Error: frame padding exp=0x00 got=0x%h",
                                {raw[11:8], raw[3:0]}));
        f = mk_frame(lcd_op_e'(raw[23:16]), {raw[15:12], raw[7:4]});
    endtask

    task automatic expect_frame(input lcd_op_e op, input logic [7:0] payload);
        lcd_frame_t f;
        int         start;
        next_frame(f, start);
        check_frame("frame", mk_frame(op, payload), f);
    endtask

    task automatic check_screen();         // the 0x80 frame is already consumed
        for (int i = 0; i < `LCD_NUM_CHARS; i++) begin
            if (i == `LCD_NUM_CHARS / 2)
                expect_frame(OP_CMD, 8'h90);            // second line
            expect_frame(OP_DATA, model[i / 4][8 * (i % 4) +: 8]);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // axi4-lite master
    ////////////////////////////////////////////////////////////
    task automatic axi_write(input logic [15:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input logic [2:0] prot);
        int gap;
        gap = int'(next_rand() % 4);                    // random B back-pressure
        S_AXI_AWADDR  <= addr;
        S_AXI_AWPROT  <= prot;
        S_AXI_WDATA   <= data;
        S_AXI_WSTRB   <= strb;
        S_AXI_AWVALID <= 1'b1;
        S_AXI_WVALID  <= 1'b1;
        do @(posedge S_AXI_ACLK); while (!S_AXI_AWREADY);
        if (!S_AXI_WREADY)
            abort_run("write data was not accepted together with the write address");
        S_AXI_AWVALID <= 1'b0;
        S_AXI_WVALID  <= 1'b0;
        repeat (gap) @(posedge S_AXI_ACLK);
        S_AXI_BREADY <= 1'b1;
        do @(posedge S_AXI_ACLK); while (!(S_AXI_BVALID && S_AXI_BREADY));
        check_resp("BRESP", S_AXI_BRESP);
        last_b = cycle_cnt;
        S_AXI_BREADY <= 1'b0;
    endtask

    task automatic axi_read(input logic [15:0] addr, output logic [31:0] data);
        int gap;
        gap = int'(next_rand() % 4);
        S_AXI_ARADDR  <= addr;
        S_AXI_ARPROT  <= 3'(next_rand());
        S_AXI_ARVALID <= 1'b1;
        do @(posedge S_AXI_ACLK); while (!S_AXI_ARREADY);
        S_AXI_ARVALID <= 1'b0;
        repeat (gap) @(posedge S_AXI_ACLK);
        S_AXI_RREADY <= 1'b1;
        do @(posedge S_AXI_ACLK); while (!(S_AXI_RVALID && S_AXI_RREADY));
        check_resp("RRESP", S_AXI_RRESP);
        data = S_AXI_RDATA;
        S_AXI_RREADY <= 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////
    initial begin
        logic [31:0] r, data, rdata;
        logic [15:0] addr;
        logic [3:0]  strb;
        lcd_frame_t  f;
        int          start;
        S_AXI_ARESETN = 1'b0;
        {S_AXI_AWVALID, S_AXI_WVALID, S_AXI_BREADY, S_AXI_ARVALID, S_AXI_RREADY} = '0;
        {S_AXI_AWADDR, S_AXI_ARADDR, S_AXI_AWPROT, S_AXI_ARPROT} = '0;
        {S_AXI_WDATA, S_AXI_WSTRB} = '0;
        for (int w = 0; w < `LCD_NUM_WORDS; w++)
            model[w] = 32'h2020_2020;                   // store comes up blank
        repeat (5) @(posedge S_AXI_ACLK);
        S_AXI_ARESETN <= 1'b1;
        expect_frame(OP_CMD, 8'h30);                    // setup sequence
        expect_frame(OP_CMD, 8'h0C);
        expect_frame(OP_CMD, 8'h01);
        expect_frame(OP_CMD, 8'h06);
        expect_frame(OP_CMD, 8'h80);
        check_screen();                                 // untouched screen
        for (int p = 0; p < N_PHASES; p++) begin
            for (int n = 0; n < N_WRITES; n++) begin
                r = next_rand();
                case (r[1:0])
                    2'd0:    addr = {10'd0, 4'(10 + r[4:2] % 6), 2'b00};   // past word 9
                    2'd1:    addr = {r[31:22] | 10'd1, r[5:2], 2'b00};     // upper bits set
                    default: addr = {10'd0, 4'(r[20:16] % 10), 2'b00};
                endcase
                data = next_rand();
                r    = next_rand();
                strb = r[3:0];
                axi_write(addr, data, strb, r[6:4]);
                if (addr[15:6] == '0 && addr[5:2] < 4'(`LCD_NUM_WORDS))
                    for (int b = 0; b < 4; b++)
                        if (strb[b])
                            model[addr[5:2]][8 * b +: 8] = data[8 * b +: 8];
            end
            do next_frame(f, start);                    // first pass after last B
            while (!(f === mk_frame(OP_CMD, 8'h80) && start > last_b));
            check_screen();
            for (int w = 0; w < `LCD_NUM_WORDS; w++) begin
                axi_read(16'(w * 4), rdata);
                check_word("RDATA", model[w], rdata);
            end
            r = next_rand();
            axi_read({10'd0, 4'(10 + r[4:2] % 6), 2'b00}, rdata);
            check_word("RDATA", '0, rdata);
            axi_read({r[31:22] | 10'd1, r[5:2], 2'b00}, rdata);
            check_word("RDATA", '0, rdata);
        end
        if (dut0.chk0.fail_cnt == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* verification/lcd_axi_checker.sv */
`timescale 1ns/10ps
`default_nettype none

`include "lcd_defines.svh"

module lcd_axi_checker (
    input wire                      S_AXI_ACLK,
    input wire                      S_AXI_ARESETN,
    input wire                      S_AXI_BVALID,
    input wire                      S_AXI_BREADY,
    input wire                      S_AXI_RVALID,
    input wire                      S_AXI_RREADY,
    input wire [`AXI_DATA_W-1:0]    S_AXI_RDATA,
    input wire                      lcd_cs,
    input wire                      lcd_sck
);

    int unsigned fail_cnt = 0;  // failed assertions so far
    logic        sck_q;         // sck one cycle back
    logic [5:0]  sck_rises;     // rising edges inside current cs window

    always_ff @(posedge S_AXI_ACLK) begin
        sck_q <= lcd_sck;
        if (!lcd_cs)
            sck_rises <= '0;                    // cleared between frames
        else if (lcd_sck && !sck_q)
            sck_rises <= sck_rises + 6'd1;
    end

    ////////////////////////////////////////////////////////////
    // axi response channels
    ////////////////////////////////////////////////////////////
    bvalid_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        S_AXI_BVALID && !S_AXI_BREADY |=> S_AXI_BVALID)
        else begin $error("BVALID dropped before BREADY"); fail_cnt++; end

    rvalid_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        S_AXI_RVALID && !S_AXI_RREADY |=> S_AXI_RVALID && $stable(S_AXI_RDATA))
        else begin $error("RVALID or RDATA moved before RREADY"); fail_cnt++; end

    ////////////////////////////////////////////////////////////
    // serial link
    ////////////////////////////////////////////////////////////
    sck_in_cs: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        $changed(lcd_sck) |-> lcd_cs || $past(lcd_cs))  // last fall shares the cs edge
        else begin $error("SCK toggled with CS low"); fail_cnt++; end

    frame_len: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        $fell(lcd_cs) |-> sck_rises == 6'd24)
        else begin $error("CS window without 24 SCK rises"); fail_cnt++; end

endmodule

bind lcd16032_axi lcd_axi_checker chk0 (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .S_AXI_BVALID  (S_AXI_BVALID),
    .S_AXI_BREADY  (S_AXI_BREADY),
    .S_AXI_RVALID  (S_AXI_RVALID),
    .S_AXI_RREADY  (S_AXI_RREADY),
    .S_AXI_RDATA   (S_AXI_RDATA),
    .lcd_cs        (lcd_cs),
    .lcd_sck       (lcd_sck)
);

`default_nettype wire

/* src/lcd16032_axi.sv */
`timescale 1ns/10ps
`default_nettype none

`include "lcd_defines.svh"

module lcd16032_axi
    import lcd_pkg::*;
(
    input  wire                         S_AXI_ACLK,
    input  wire                         S_AXI_ARESETN,
    output logic                        S_AXI_AWREADY,
    input  wire [`AXI_ADDR_W-1:0]       S_AXI_AWADDR,
    input  wire                         S_AXI_AWVALID,
    input  wire [2:0]                   S_AXI_AWPROT,
    output logic                        S_AXI_WREADY,
    input  wire [`AXI_DATA_W-1:0]       S_AXI_WDATA,
    input  wire [`AXI_DATA_W/8-1:0]     S_AXI_WSTRB,
    input  wire                         S_AXI_WVALID,
    output logic [1:0]                  S_AXI_BRESP,
    output logic                        S_AXI_BVALID,
    input  wire                         S_AXI_BREADY,
    output logic                        S_AXI_ARREADY,
    input  wire [`AXI_ADDR_W-1:0]       S_AXI_ARADDR,
    input  wire                         S_AXI_ARVALID,
    input  wire [2:0]                   S_AXI_ARPROT,
    output logic [1:0]                  S_AXI_RRESP,
    output logic                        S_AXI_RVALID,
    output logic [`AXI_DATA_W-1:0]      S_AXI_RDATA,
    input  wire                         S_AXI_RREADY,
    output logic                        lcd_cs,
    output logic                        lcd_sck,
    output logic                        lcd_mosi
);

    char_wr_t               char_wr;    // slave -> store
    logic                   wr_en;
    logic [3:0]             rd_index;
    logic [`AXI_DATA_W-1:0] rd_word;
    logic                   chr_rd;     // sequencer <-> store
    logic [5:0]             char_addr;
    logic [7:0]             chr_byte;
    lcd_frame_t             frame;      // sequencer <-> shifter
    logic                   tx_start;
    logic                   tx_done;
    logic                   tmr_start;  // sequencer <-> timer
    logic                   tmr_expire;

    lcd_axi_slave u_axi (.*);

    lcd_char_ram u_ram (.*);

    lcd_refresh_fsm u_fsm (.*);

    lcd_op_timer u_tmr (.*);

    lcd_serial_tx u_tx (.*);

endmodule

`default_nettype wire

/* src/lcd_serial_tx.sv */
`timescale 1ns/10ps
`default_nettype none

`include "lcd_defines.svh"

module lcd_serial_tx
    import lcd_pkg::*;
(
    input  wire             S_AXI_ACLK,
    input  wire             S_AXI_ARESETN,
    input  wire             tx_start,
    input  wire lcd_frame_t frame,
    output logic            tx_done,
    output logic            lcd_cs,
    output logic            lcd_sck,
    output logic            lcd_mosi
);

    localparam int DW = $clog2(2 * `LCD_SCK_HALF);

    logic [23:0]   shreg;       // msb on the wire
    logic [4:0]    bit_cnt;     // 0..23
    logic [DW-1:0] div_cnt;     // position inside one bit
    logic [23:0]   frame_bits;

    // sync, high nibble << 4, low nibble << 4
    assign frame_bits = {frame.op, frame.payload[7:4], 4'h0, frame.payload[3:0], 4'h0};
    assign lcd_mosi   = shreg[23];

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            shreg   <= '0;
            bit_cnt <= '0;
            div_cnt <= '0;
            lcd_cs  <= 1'b0;
            lcd_sck <= 1'b0;
            tx_done <= 1'b0;
        end else begin
            tx_done <= 1'b0;
            if (tx_start && !lcd_cs) begin
                lcd_cs  <= 1'b1;                // bit 23 already on mosi
                lcd_sck <= 1'b0;
                shreg   <= frame_bits;
                bit_cnt <= '0;
                div_cnt <= '0;
            end else if (lcd_cs) begin
                if (div_cnt == DW'(`LCD_SCK_HALF - 1)) begin
                    lcd_sck <= 1'b1;            // slave samples here
                    div_cnt <= div_cnt + 1'b1;
                end else if (div_cnt == DW'(2 * `LCD_SCK_HALF - 1)) begin
                    lcd_sck <= 1'b0;            // mosi moves on the fall
                    div_cnt <= '0;
                    shreg   <= shreg << 1;      // zero after the last bit
                    if (bit_cnt == 5'd23) begin
                        lcd_cs  <= 1'b0;
                        tx_done <= 1'b1;
                    end else begin
                        bit_cnt <= bit_cnt + 5'd1;
                    end
                end else begin
                    div_cnt <= div_cnt + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* src/lcd_op_timer.sv */
`timescale 1ns/10ps
`default_nettype none

`include "lcd_defines.svh"

module lcd_op_timer (
    input  wire     S_AXI_ACLK,
    input  wire     S_AXI_ARESETN,
    input  wire     tmr_start,
    output logic    tmr_expire
);

    localparam int CW = $clog2(`LCD_OP_DELAY + 1);

    logic [CW-1:0] cnt;         // zero when idle

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            cnt        <= '0;
            tmr_expire <= 1'b0;
        end else begin
            tmr_expire <= 1'b0;
            if (tmr_start) begin
                cnt <= CW'(`LCD_OP_DELAY - 1);  // restart also while counting
            end else if (cnt != '0) begin
                cnt <= cnt - 1'b1;
                if (cnt == CW'(1))
                    tmr_expire <= 1'b1;         // lands on the cycle count hits zero
            end
        end
    end

endmodule

`default_nettype wire

/* src/lcd_refresh_fsm.sv */
`timescale 1ns/10ps
`default_nettype none

`include "lcd_defines.svh"

module lcd_refresh_fsm
    import lcd_pkg::*;
(
    input  wire         S_AXI_ACLK,
    input  wire         S_AXI_ARESETN,
    output logic        chr_rd,
    output logic [5:0]  char_addr,
    input  wire [7:0]   chr_byte,
    output logic        tx_start,
    output lcd_frame_t  frame,
    input  wire         tx_done,
    output logic        tmr_start,
    input  wire         tmr_expire
);

    // function set, display on, clear, entry mode
    localparam logic [7:0] INIT_CMDS [4] = '{8'h30, 8'h0C, 8'h01, 8'h06};
    localparam int         HALF_CHARS    = `LCD_NUM_CHARS / 2;     // chars per line

    lcd_state_e state;
    logic [1:0] init_idx;       // which setup command
    logic       init_done;
    logic       line_pend;      // next frame is a line address
    logic [5:0] char_idx;       // 0..39

    assign chr_rd    = (state == CHAR_READ);
    assign char_addr = char_idx;

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            state     <= RESET_WAIT;
            init_idx  <= 2'd0;
            init_done <= 1'b0;
            line_pend <= 1'b1;                  // pass starts with 0x80
            char_idx  <= 6'd0;
            tx_start  <= 1'b0;
            tmr_start <= 1'b0;
        end else begin
            tx_start  <= 1'b0;
            tmr_start <= 1'b0;
            case (state)
                RESET_WAIT: state <= INIT_CMD;
                INIT_CMD: begin
                    tx_start <= 1'b1;
                    state    <= WAIT_DONE;
                end
                LINE_CMD: begin
                    tx_start  <= 1'b1;
                    line_pend <= 1'b0;
                    state     <= WAIT_DONE;
                end
                CHAR_READ: state <= CHAR_SEND;  // store registers the byte
                CHAR_SEND: begin
                    tx_start <= 1'b1;
                    state    <= WAIT_DONE;
                    if (char_idx == 6'(`LCD_NUM_CHARS - 1)) begin
                        char_idx  <= 6'd0;      // wrap, new pass
                        line_pend <= 1'b1;
                    end else begin
                        char_idx <= char_idx + 6'd1;
                        if (char_idx == 6'(HALF_CHARS - 1))
                            line_pend <= 1'b1;  // second line next
                    end
                end
                WAIT_DONE: begin
                    if (tx_done) begin
                        tmr_start <= 1'b1;
                        state     <= WAIT_TIMER;
                    end
                end
                WAIT_TIMER: begin
                    if (tmr_expire) begin
                        if (!init_done) begin
                            if (init_idx == 2'd3) begin
                                init_done <= 1'b1;
                                state     <= LINE_CMD;
                            end else begin
                                init_idx <= init_idx + 2'd1;
                                state    <= INIT_CMD;
                            end
                        end else if (line_pend) begin
                            state <= LINE_CMD;
                        end else begin
                            state <= CHAR_READ;
                        end
                    end
                end
                default: state <= RESET_WAIT;
            endcase
        end
    end

    // frame contents, loaded alongside tx_start
    always_ff @(posedge S_AXI_ACLK) begin
        case (state)
            INIT_CMD: begin
                frame.op      <= OP_CMD;
                frame.payload <= INIT_CMDS[init_idx];
            end
            LINE_CMD: begin
                frame.op      <= OP_CMD;
                frame.payload <= (char_idx < 6'(HALF_CHARS)) ? 8'h80 : 8'h90;
            end
            CHAR_SEND: begin
                frame.op      <= OP_DATA;
                frame.payload <= chr_byte;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* src/lcd_char_ram.sv */
`timescale 1ns/10ps
`default_nettype none

`include "lcd_defines.svh"

module lcd_char_ram
    import lcd_pkg::*;
(
    input  wire                     S_AXI_ACLK,
    input  wire                     S_AXI_ARESETN,
    input  wire char_wr_t           char_wr,
    input  wire                     wr_en,
    input  wire [3:0]               rd_index,
    output logic [`AXI_DATA_W-1:0]  rd_word,
    input  wire                     chr_rd,
    input  wire [5:0]               char_addr,
    output logic [7:0]              chr_byte
);

    logic [`AXI_DATA_W-1:0] mem [`LCD_NUM_WORDS];   // char 0 in low byte of word 0
    logic [`AXI_DATA_W-1:0] chr_word;               // word holding char_addr

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            for (int w = 0; w < `LCD_NUM_WORDS; w++)
                mem[w] <= {(`AXI_DATA_W/8){8'h20}}; // blank screen
        end else if (wr_en) begin
            for (int b = 0; b < `AXI_DATA_W/8; b++)
                if (char_wr.strb[b])
                    mem[char_wr.index][8*b +: 8] <= char_wr.data[8*b +: 8];
        end
    end

    // bus side, combinational
    assign rd_word  = (rd_index < 4'(`LCD_NUM_WORDS)) ? mem[rd_index] : '0;

    // sequencer side, byte out one cycle after chr_rd
    assign chr_word = mem[char_addr[5:2]];

    always_ff @(posedge S_AXI_ACLK) begin
        if (chr_rd)
            chr_byte <= chr_word[{char_addr[1:0], 3'b000} +: 8];
    end

endmodule

`default_nettype wire

/* src/lcd_axi_slave.sv */
`timescale 1ns/10ps
`default_nettype none

`include "lcd_defines.svh"

module lcd_axi_slave
    import lcd_pkg::*;
(
    input  wire                         S_AXI_ACLK,
    input  wire                         S_AXI_ARESETN,
    // write address / data / response
    output logic                        S_AXI_AWREADY,
    input  wire [`AXI_ADDR_W-1:0]       S_AXI_AWADDR,
    input  wire                         S_AXI_AWVALID,
    input  wire [2:0]                   S_AXI_AWPROT,   // ignored
    output logic                        S_AXI_WREADY,
    input  wire [`AXI_DATA_W-1:0]       S_AXI_WDATA,
    input  wire [`AXI_DATA_W/8-1:0]     S_AXI_WSTRB,
    input  wire                         S_AXI_WVALID,
    output logic [1:0]                  S_AXI_BRESP,
    output logic                        S_AXI_BVALID,
    input  wire                         S_AXI_BREADY,
    // read address / data
    output logic                        S_AXI_ARREADY,
    input  wire [`AXI_ADDR_W-1:0]       S_AXI_ARADDR,
    input  wire                         S_AXI_ARVALID,
    input  wire [2:0]                   S_AXI_ARPROT,   // ignored
    output logic [1:0]                  S_AXI_RRESP,
    output logic                        S_AXI_RVALID,
    output logic [`AXI_DATA_W-1:0]      S_AXI_RDATA,
    input  wire                         S_AXI_RREADY,
    // store side
    output char_wr_t                    char_wr,
    output logic                        wr_en,
    output logic [3:0]                  rd_index,
    input  wire [`AXI_DATA_W-1:0]       rd_word
);

    logic aw_hit;               // write address inside the store
    logic ar_hit;               // read address inside the store

    // word index from byte address, upper bits must be zero
    assign aw_hit = (S_AXI_AWADDR[`AXI_ADDR_W-1:6] == '0) &&
                    (S_AXI_AWADDR[5:2] < 4'(`LCD_NUM_WORDS));
    assign ar_hit = (S_AXI_ARADDR[`AXI_ADDR_W-1:6] == '0) &&
                    (S_AXI_ARADDR[5:2] < 4'(`LCD_NUM_WORDS));

    ////////////////////////////////////////////////////////////
    // write channel
    ////////////////////////////////////////////////////////////
    assign S_AXI_WREADY  = S_AXI_AWREADY;       // aw and w accepted together
    assign S_AXI_BRESP   = 2'b00;               // always okay
    assign char_wr.index = S_AXI_AWADDR[5:2];
    assign char_wr.data  = S_AXI_WDATA;
    assign char_wr.strb  = S_AXI_WSTRB;
    assign wr_en         = S_AXI_AWREADY && aw_hit; // store writes on this edge

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            S_AXI_AWREADY <= 1'b0;
            S_AXI_BVALID  <= 1'b0;
        end else begin
            S_AXI_AWREADY <= 1'b0;                  // single-cycle pulse
            if (!S_AXI_AWREADY && !S_AXI_BVALID && S_AXI_AWVALID && S_AXI_WVALID)
                S_AXI_AWREADY <= 1'b1;
            if (S_AXI_AWREADY)
                S_AXI_BVALID <= 1'b1;               // response next cycle
            else if (S_AXI_BREADY)
                S_AXI_BVALID <= 1'b0;               // held until taken
        end
    end

    ////////////////////////////////////////////////////////////
    // read channel
    ////////////////////////////////////////////////////////////
    assign S_AXI_RRESP = 2'b00;
    assign rd_index    = S_AXI_ARADDR[5:2];         // store answers combinationally

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            S_AXI_ARREADY <= 1'b0;
            S_AXI_RVALID  <= 1'b0;
        end else begin
            S_AXI_ARREADY <= 1'b0;
            if (!S_AXI_ARREADY && !S_AXI_RVALID && S_AXI_ARVALID)
                S_AXI_ARREADY <= 1'b1;              // one read in flight at most
            if (S_AXI_ARREADY)
                S_AXI_RVALID <= 1'b1;
            else if (S_AXI_RREADY)
                S_AXI_RVALID <= 1'b0;
        end
    end

    // read data captured with the address handshake
    always_ff @(posedge S_AXI_ACLK) begin
        if (S_AXI_ARREADY)
            S_AXI_RDATA <= ar_hit ? rd_word : '0;   // unmapped reads as zero
    end

endmodule

`default_nettype wire

/* src/lcd_pkg.sv */
`default_nettype none

`include "lcd_defines.svh"

package lcd_pkg;

    // sequencer states
    typedef enum int unsigned {
        RESET_WAIT,             // one idle cycle out of reset
        INIT_CMD,               // setup command
        LINE_CMD,               // ddram line address
        CHAR_READ,              // fetch from store
        CHAR_SEND,              // fetched byte goes out
        WAIT_DONE,              // shifter busy
        WAIT_TIMER              // post-frame gap
    } lcd_state_e;

    // sync byte leading every frame
    typedef enum logic [7:0] {
        OP_CMD  = 8'hF8,        // rs=0, instruction
        OP_DATA = 8'hFA         // rs=1, data
    } lcd_op_e;

    typedef struct packed {
        lcd_op_e    op;         // sync byte
        logic [7:0] payload;    // command or char code
    } lcd_frame_t;

    typedef struct packed {
        logic [3:0]                 index;  // word index 0..9
        logic [`AXI_DATA_W-1:0]     data;
        logic [`AXI_DATA_W/8-1:0]   strb;   // byte lanes
    } char_wr_t;

endpackage

`default_nettype wire

/* src/lcd_defines.svh */
`ifndef LCD_DEFINES_SVH
`define LCD_DEFINES_SVH

////////////////////////////////////////////////////////////
// bus widths
////////////////////////////////////////////////////////////
`define AXI_ADDR_W      16      // byte address
`define AXI_DATA_W      32      // one word, four chars

////////////////////////////////////////////////////////////
// screen and store geometry
////////////////////////////////////////////////////////////
`define LCD_NUM_CHARS   40      // 2 lines x 20 half-width chars
`define LCD_NUM_WORDS   10      // 40 chars / 4 per word

////////////////////////////////////////////////////////////
// serial timing, in clock cycles
////////////////////////////////////////////////////////////
`define LCD_SCK_HALF    2       // half period of sck
`define LCD_OP_DELAY    16      // gap after each frame

`endif
